// ==== rvIsaPkg.sv ====
// rv32i instruction-set constants and the three views of an instruction word
package rvIsaPkg;

  localparam int xlen     = 32; // integer data width
  localparam int regAddrW = 5;  // x0..x31

  ////////////////////
  // major opcodes, only the alu ones survive
  localparam logic [6:0] opcOp    = 7'b0110011; // reg-reg
  localparam logic [6:0] opcOpImm = 7'b0010011; // reg-imm
  localparam logic [6:0] opcLui   = 7'b0110111;
  localparam logic [6:0] opcAuipc = 7'b0010111;

  // funct3 per operation
  localparam logic [2:0] f3AddSub = 3'b000;
  localparam logic [2:0] f3Sll    = 3'b001;
  localparam logic [2:0] f3Slt    = 3'b010;
  localparam logic [2:0] f3Sltu   = 3'b011;
  localparam logic [2:0] f3Xor    = 3'b100;
  localparam logic [2:0] f3SrlSra = 3'b101;
  localparam logic [2:0] f3Or     = 3'b110;
  localparam logic [2:0] f3And    = 3'b111;

  // funct7, shift-immediates reuse these in imm[11:5]
  localparam logic [6:0] baseFunct7 = 7'b0000000;
  localparam logic [6:0] altFunct7  = 7'b0100000; // sub / sra

  ////////////////////
  // same 32 bits, decoded as R, I or U format
  typedef union packed {
    struct packed {
      logic [6:0]          funct7;
      logic [regAddrW-1:0] rs2;
      logic [regAddrW-1:0] rs1;
      logic [2:0]          funct3;
      logic [regAddrW-1:0] rd;
      logic [6:0]          opcode;
    } rType;
    struct packed {
      logic [11:0]         imm12;  // sign-extended by decode
      logic [regAddrW-1:0] rs1;
      logic [2:0]          funct3;
      logic [regAddrW-1:0] rd;
      logic [6:0]          opcode;
    } iType;
    struct packed {
      logic [19:0]         imm20;  // lands in [31:12]
      logic [regAddrW-1:0] rd;
      logic [6:0]          opcode;
    } uType;
  } instrWordU;

endpackage

// ==== corePipePkg.sv ====
// pipeline constants: alu operation codes, register count and pc sequencing
package corePipePkg;

  ////////////////////
  // alu operation select
  localparam int aluOpW = 4;

  localparam logic [aluOpW-1:0] aluAdd   = 4'd0;
  localparam logic [aluOpW-1:0] aluSub   = 4'd1;
  localparam logic [aluOpW-1:0] aluSll   = 4'd2;
  localparam logic [aluOpW-1:0] aluSlt   = 4'd3;  // signed compare
  localparam logic [aluOpW-1:0] aluSltu  = 4'd4;  // unsigned compare
  localparam logic [aluOpW-1:0] aluXor   = 4'd5;
  localparam logic [aluOpW-1:0] aluSrl   = 4'd6;
  localparam logic [aluOpW-1:0] aluSra   = 4'd7;
  localparam logic [aluOpW-1:0] aluOr    = 4'd8;
  localparam logic [aluOpW-1:0] aluAnd   = 4'd9;
  localparam logic [aluOpW-1:0] aluPassB = 4'd10; // lui, operand b straight out
  // 11..15 unused, alu gives zero

  ////////////////////
  // pc rules
  // first accepted instruction gets resetPc
  localparam logic [31:0] resetPc = 32'h0000_1000;
  // no compressed words, so every step is one word
  localparam logic [31:0] pcStep  = 32'd4;

  ////////////////////
  // register file
  // x0 included, it is never stored
  localparam int nRegs = 32;

endpackage

// ==== fetchStage.sv ====
// fetch stage: takes an offered instruction word, tags it with its pc, registers both
`timescale 1ns/1ps

module fetchStage (
  input  logic        clk,
  input  logic        rstN,
  input  logic        stall,      // global freeze
  input  logic        instrValid, // one-cycle strobe
  input  logic [31:0] instr,
  output logic        fValid,
  output logic [31:0] fPc,
  output logic [31:0] fInstr
);

  logic [31:0] nextPc; // pc for the next accepted word
  logic        accept;

  assign accept = instrValid & ~stall; // strobe ignored while stalled

  // control: pc counter and valid bit
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      nextPc <= corePipePkg::resetPc;
      fValid <= 1'b0;
    end else if (!stall) begin
      fValid <= instrValid; // bubble when nothing offered
      if (accept) nextPc <= nextPc + corePipePkg::pcStep;
    end
  end

  // payload, only loaded on accept
  always_ff @(posedge clk) begin
    if (accept) begin
      fPc    <= nextPc;
      fInstr <= instr;
    end
  end

endmodule

// ==== regFile.sv ====
// integer register file with 31 stored registers, x0 reading zero and write-through on read
`timescale 1ns/1ps

module regFile (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         stall,
  input  logic [rvIsaPkg::regAddrW-1:0] rs1,
  input  logic [rvIsaPkg::regAddrW-1:0] rs2,
  input  logic                         wbWe,
  input  logic [rvIsaPkg::regAddrW-1:0] wbAddr,
  input  logic [rvIsaPkg::xlen-1:0]     wbData,
  output logic [rvIsaPkg::xlen-1:0]     rs1Data,
  output logic [rvIsaPkg::xlen-1:0]     rs2Data
);

  logic [rvIsaPkg::xlen-1:0] regs [1:corePipePkg::nRegs-1]; // no storage for x0

  // one read port where a same-cycle write wins over the stored copy
  function automatic logic [rvIsaPkg::xlen-1:0] readPort(
    input logic [rvIsaPkg::regAddrW-1:0] addr
  );
    if (addr == '0) return '0;
    if (wbWe && (wbAddr == addr)) return wbData; // two-ahead producer
    return regs[addr];
  endfunction

  // both read ports follow the stored regs and the write port too
  always_comb begin
    rs1Data = readPort(rs1);
    rs2Data = readPort(rs2);
  end

  // writes frozen under stall
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 1; i < corePipePkg::nRegs; i++) regs[i] <= '0;
    end else if (wbWe && !stall && (wbAddr != '0)) begin
      regs[wbAddr] <= wbData;
    end
  end

endmodule

// ==== decodeStage.sv ====
// decode stage: decodes the word, reads operands, flags illegal words, registers the op
`timescale 1ns/1ps

module decodeStage (
  input  logic                            clk,
  input  logic                            rstN,
  input  logic                            stall,
  input  logic                            fValid,
  input  logic [rvIsaPkg::xlen-1:0]       fPc,
  input  logic [31:0]                     fInstr,
  input  logic                            wbWe,     // write port from writeback
  input  logic [rvIsaPkg::regAddrW-1:0]   wbAddr,
  input  logic [rvIsaPkg::xlen-1:0]       wbData,
  output logic                            dValid,
  output logic [rvIsaPkg::xlen-1:0]       dPc,
  output logic [rvIsaPkg::regAddrW-1:0]   dRd,      // raw rd field
  output logic                            dWrite,
  output logic                            dIllegal,
  output logic [corePipePkg::aluOpW-1:0]  dAluOp,
  output logic [rvIsaPkg::regAddrW-1:0]   dRs1,
  output logic [rvIsaPkg::regAddrW-1:0]   dRs2,
  output logic                            dUseRs1,  // for forwarding compare
  output logic                            dUseRs2,
  output logic [rvIsaPkg::xlen-1:0]       dOpA,
  output logic [rvIsaPkg::xlen-1:0]       dOpB
);

  rvIsaPkg::instrWordU                   iw;
  logic [rvIsaPkg::xlen-1:0]             rs1Data, rs2Data, immI, immU, opA, opB;
  logic [corePipePkg::aluOpW-1:0]        aluOp;
  logic                                  useRs1, useRs2, write, illegal;

  assign iw   = fInstr;
  assign immI = {{20{iw.iType.imm12[11]}}, iw.iType.imm12};
  assign immU = {iw.uType.imm20, 12'b0};

  regFile u_regFile (
    .clk, .rstN, .stall,
    .rs1(iw.rType.rs1), .rs2(iw.rType.rs2),
    .wbWe, .wbAddr, .wbData,
    .rs1Data, .rs2Data
  );

  ////////////////////
  // opcode / funct decode
  always_comb begin
    aluOp = corePipePkg::aluAdd;
    opA = rs1Data; opB = rs2Data;
    useRs1 = 1'b0; useRs2 = 1'b0; write = 1'b1; illegal = 1'b0;
    case (iw.rType.opcode)
      rvIsaPkg::opcOp, rvIsaPkg::opcOpImm: begin
        useRs1 = 1'b1;
        case (iw.rType.funct3)
          rvIsaPkg::f3AddSub: aluOp = corePipePkg::aluAdd;
          rvIsaPkg::f3Sll:    aluOp = corePipePkg::aluSll;
          rvIsaPkg::f3Slt:    aluOp = corePipePkg::aluSlt;
          rvIsaPkg::f3Sltu:   aluOp = corePipePkg::aluSltu;
          rvIsaPkg::f3Xor:    aluOp = corePipePkg::aluXor;
          rvIsaPkg::f3SrlSra: aluOp = corePipePkg::aluSrl;
          rvIsaPkg::f3Or:     aluOp = corePipePkg::aluOr;
          default:            aluOp = corePipePkg::aluAnd;
        endcase
        if (iw.rType.opcode == rvIsaPkg::opcOp) begin
          useRs2 = 1'b1;
          if (iw.rType.funct7 == rvIsaPkg::altFunct7) begin // only sub and sra
            if (iw.rType.funct3 == rvIsaPkg::f3AddSub) aluOp = corePipePkg::aluSub;
            else if (iw.rType.funct3 == rvIsaPkg::f3SrlSra) aluOp = corePipePkg::aluSra;
            else illegal = 1'b1;
          end else if (iw.rType.funct7 != rvIsaPkg::baseFunct7) illegal = 1'b1;
        end else begin
          opB = immI;
          // shift-imm: upper imm bits act as funct7
          if (iw.iType.funct3 == rvIsaPkg::f3Sll)
            illegal = (iw.iType.imm12[11:5] != rvIsaPkg::baseFunct7);
          else if (iw.iType.funct3 == rvIsaPkg::f3SrlSra) begin
            if (iw.iType.imm12[11:5] == rvIsaPkg::altFunct7) aluOp = corePipePkg::aluSra;
            else illegal = (iw.iType.imm12[11:5] != rvIsaPkg::baseFunct7);
          end
        end
      end
      rvIsaPkg::opcLui: begin
        aluOp = corePipePkg::aluPassB; opB = immU;
      end
      rvIsaPkg::opcAuipc: begin
        opA = fPc; opB = immU; // aluAdd
      end
      default: illegal = 1'b1;
    endcase
    if (illegal || (iw.uType.rd == '0)) write = 1'b0; // x0 writes dropped
  end

  // control bits, bubbles carry nothing
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      {dValid, dWrite, dIllegal, dUseRs1, dUseRs2} <= '0;
    end else if (!stall) begin
      dValid   <= fValid;
      dWrite   <= fValid & write;
      dIllegal <= fValid & illegal;
      dUseRs1  <= fValid & useRs1;
      dUseRs2  <= fValid & useRs2;
    end
  end

  // payload
  always_ff @(posedge clk) begin
    if (!stall) begin
      dPc <= fPc; dRd <= iw.rType.rd; dAluOp <= aluOp;
      dRs1 <= iw.rType.rs1; dRs2 <= iw.rType.rs2;
      dOpA <= opA; dOpB <= opB;
    end
  end

endmodule

// ==== executeStage.sv ====
// execute stage: forwards from the next-older instruction, runs the alu, registers the result
`timescale 1ns/1ps

module executeStage (
  input  logic                            clk,
  input  logic                            rstN,
  input  logic                            stall,
  input  logic                            dValid,
  input  logic [rvIsaPkg::xlen-1:0]       dPc,
  input  logic [rvIsaPkg::regAddrW-1:0]   dRd,
  input  logic                            dWrite,
  input  logic                            dIllegal,
  input  logic [corePipePkg::aluOpW-1:0]  dAluOp,
  input  logic [rvIsaPkg::regAddrW-1:0]   dRs1,
  input  logic [rvIsaPkg::regAddrW-1:0]   dRs2,
  input  logic                            dUseRs1,
  input  logic                            dUseRs2,
  input  logic [rvIsaPkg::xlen-1:0]       dOpA,
  input  logic [rvIsaPkg::xlen-1:0]       dOpB,
  output logic                            eValid,
  output logic [rvIsaPkg::xlen-1:0]       ePc,
  output logic [rvIsaPkg::regAddrW-1:0]   eRd,
  output logic                            eWrite,
  output logic                            eIllegal,
  output logic [rvIsaPkg::xlen-1:0]       eResult
);

  logic [rvIsaPkg::xlen-1:0] opA, opB, aluRes;
  logic [4:0]                shamt;
  logic                      fwdA, fwdB;

  ////////////////////
  // forwarding from the execute register
  // eWrite is already clear for x0 and illegal words
  assign fwdA = eValid & eWrite & dUseRs1 & (eRd == dRs1);
  assign fwdB = eValid & eWrite & dUseRs2 & (eRd == dRs2);
  assign opA  = fwdA ? eResult : dOpA;
  assign opB  = fwdB ? eResult : dOpB;  // imm ops never set dUseRs2
  assign shamt = opB[4:0];

  ////////////////////
  // alu
  always_comb begin
    case (dAluOp)
      corePipePkg::aluAdd:   aluRes = opA + opB;
      corePipePkg::aluSub:   aluRes = opA - opB;
      corePipePkg::aluSll:   aluRes = opA << shamt;
      corePipePkg::aluSlt:   aluRes = {31'b0, $signed(opA) < $signed(opB)};
      corePipePkg::aluSltu:  aluRes = {31'b0, opA < opB};
      corePipePkg::aluXor:   aluRes = opA ^ opB;
      corePipePkg::aluSrl:   aluRes = opA >> shamt;
      corePipePkg::aluSra:   aluRes = $unsigned($signed(opA) >>> shamt);
      corePipePkg::aluOr:    aluRes = opA | opB;
      corePipePkg::aluAnd:   aluRes = opA & opB;
      corePipePkg::aluPassB: aluRes = opB;
      default:               aluRes = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      {eValid, eWrite, eIllegal} <= '0;
    end else if (!stall) begin
      eValid   <= dValid;
      eWrite   <= dValid & dWrite;
      eIllegal <= dValid & dIllegal;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      ePc     <= dPc;
      eRd     <= dRd;
      eResult <= dIllegal ? '0 : aluRes; // illegal words retire zero
    end
  end

endmodule

// ==== writebackStage.sv ====
// writeback stage: drives the register-file write port and registers the retire record
`timescale 1ns/1ps

module writebackStage (
  input  logic                          clk,
  input  logic                          rstN,
  input  logic                          stall,
  input  logic                          eValid,
  input  logic [rvIsaPkg::xlen-1:0]     ePc,
  input  logic [rvIsaPkg::regAddrW-1:0] eRd,
  input  logic                          eWrite,
  input  logic                          eIllegal,
  input  logic [rvIsaPkg::xlen-1:0]     eResult,
  output logic                          wbWe,
  output logic [rvIsaPkg::regAddrW-1:0] wbAddr,
  output logic [rvIsaPkg::xlen-1:0]     wbData,
  output logic                          retireValid,
  output logic [rvIsaPkg::xlen-1:0]     retirePc,
  output logic [rvIsaPkg::regAddrW-1:0] retireRd,
  output logic                          retireIllegal,
  output logic [rvIsaPkg::xlen-1:0]     retireResult
);

  // write port straight off the execute register, lands on the retire edge
  assign wbWe   = eValid & eWrite;
  assign wbAddr = eRd;
  assign wbData = eResult;

  ////////////////////
  // retire record, held while stalled
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      retireValid   <= 1'b0;
      retireIllegal <= 1'b0;
      retirePc      <= '0;
      retireRd      <= '0;
      retireResult  <= '0;
    end else if (!stall) begin
      retireValid   <= eValid;      // one pulse per instruction
      retireIllegal <= eValid & eIllegal;
      retirePc      <= ePc;
      retireRd      <= eIllegal ? '0 : eRd;
      retireResult  <= eResult;
    end
  end

endmodule

// ==== rv32Pipe.sv ====
// rv32Pipe top: four-stage rv32i alu pipeline, fetch to writeback under one global stall
`timescale 1ns/1ps

module rv32Pipe (
  input  logic                          clk,
  input  logic                          rstN,
  input  logic                          stall,        // freezes every stage
  input  logic                          instrValid,
  input  logic [31:0]                   instr,
  output logic                          retireValid,
  output logic [rvIsaPkg::xlen-1:0]     retirePc,
  output logic [rvIsaPkg::regAddrW-1:0] retireRd,
  output logic [rvIsaPkg::xlen-1:0]     retireResult,
  output logic                          retireIllegal
);

  // fetch -> decode
  logic                                 fValid;
  logic [rvIsaPkg::xlen-1:0]            fPc;
  logic [31:0]                          fInstr;

  // decode -> execute
  logic                                 dValid, dWrite, dIllegal, dUseRs1, dUseRs2;
  logic [rvIsaPkg::xlen-1:0]            dPc, dOpA, dOpB;
  logic [rvIsaPkg::regAddrW-1:0]        dRd, dRs1, dRs2;
  logic [corePipePkg::aluOpW-1:0]       dAluOp;

  // execute -> writeback
  logic                                 eValid, eWrite, eIllegal;
  logic [rvIsaPkg::xlen-1:0]            ePc, eResult;
  logic [rvIsaPkg::regAddrW-1:0]        eRd;

  // writeback -> register file in decode
  logic                                 wbWe;
  logic [rvIsaPkg::regAddrW-1:0]        wbAddr;
  logic [rvIsaPkg::xlen-1:0]            wbData;

  fetchStage u_fetch (
    .clk, .rstN, .stall, .instrValid, .instr,
    .fValid, .fPc, .fInstr
  );

  decodeStage u_decode (
    .clk, .rstN, .stall, .fValid, .fPc, .fInstr,
    .wbWe, .wbAddr, .wbData,
    .dValid, .dPc, .dRd, .dWrite, .dIllegal, .dAluOp,
    .dRs1, .dRs2, .dUseRs1, .dUseRs2, .dOpA, .dOpB
  );

  executeStage u_execute (
    .clk, .rstN, .stall,
    .dValid, .dPc, .dRd, .dWrite, .dIllegal, .dAluOp,
    .dRs1, .dRs2, .dUseRs1, .dUseRs2, .dOpA, .dOpB,
    .eValid, .ePc, .eRd, .eWrite, .eIllegal, .eResult
  );

  writebackStage u_writeback (
    .clk, .rstN, .stall,
    .eValid, .ePc, .eRd, .eWrite, .eIllegal, .eResult,
    .wbWe, .wbAddr, .wbData,
    .retireValid, .retirePc, .retireRd, .retireIllegal, .retireResult
  );

endmodule

// ==== rv32Pipe_sva.sv ====
// retire-interface assertions for rv32Pipe, bound into the top level
`timescale 1ns/1ps

module rv32PipeSva (
  input logic        clk,
  input logic        rstN,
  input logic        stall,
  input logic        retireValid,
  input logic [31:0] retirePc,
  input logic [4:0]  retireRd,
  input logic [31:0] retireResult,
  input logic        retireIllegal
);

  logic [31:0] lastPc;     // pc of the previous retirement
  logic        seenRetire;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      lastPc     <= '0;
      seenRetire <= 1'b0;
    end else if (retireValid && !stall) begin // record consumed on this edge
      lastPc     <= retirePc;
      seenRetire <= 1'b1;
    end
  end

  ////////////////////
  aQuietAfterReset: assert property (@(posedge clk) $rose(rstN) |-> !retireValid)
    else $error("retireValid high on the first edge after reset");

  // frozen record while stalled
  aStallHolds: assert property (@(posedge clk) disable iff (!rstN)
    stall |=> $stable({retireValid, retirePc, retireRd, retireResult, retireIllegal}))
    else $error("retire outputs changed under stall");

  aIllegalValid: assert property (@(posedge clk) disable iff (!rstN)
    retireIllegal |-> retireValid)
    else $error("retireIllegal without retireValid");

  aPcStep: assert property (@(posedge clk) disable iff (!rstN)
    (retireValid && !stall && seenRetire) |-> (retirePc == lastPc + 32'd4))
    else $error("retirePc did not advance by 4");

endmodule

bind rv32Pipe rv32PipeSva u_sva (
  .clk(clk), .rstN(rstN), .stall(stall), .retireValid(retireValid),
  .retirePc(retirePc), .retireRd(retireRd), .retireResult(retireResult),
  .retireIllegal(retireIllegal)
);

// ==== rv32PipeTb.sv ====
// rv32Pipe testbench: replays instruction vectors under random stall and idle gaps
`timescale 1ns/1ps

module rv32PipeTb;

  localparam int nVec      = 29;
  localparam int maxGap    = 3;  // idle cycles before an offer
  localparam int maxStall  = 3;  // stalled cycles before an offer
  localparam int timeoutNs = nVec * (3 + maxGap + maxStall) * 8 + 400; // margin covers reset, drain

  logic        clk, rstN, stall, instrValid;
  logic [31:0] instr;
  logic        retireValid, retireIllegal;
  logic [31:0] retirePc, retireResult;
  logic [4:0]  retireRd;

  logic [31:0] vecMem [0:4*nVec-1]; // word, rd, result, illegal per vector
  int          expIdx[$];           // vector index per accepted instruction
  int          accEdge[$];          // unstalled edge number at acceptance
  int          edgeCount    = 0;
  int          offerCount   = 0;
  int          retiredCount = 0;
  int          errCount     = 0;
  int          idx, acc;
  logic        fileBad      = 1'b0;
  integer      seed;

  rv32Pipe u_dut (
    .clk, .rstN, .stall, .instrValid, .instr,
    .retireValid, .retirePc, .retireRd, .retireResult, .retireIllegal
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk; // 8 ns period
  end

  task automatic checkValue(input string name, input logic [31:0] expV,
                            input logic [31:0] actV);
    if (actV !== expV) begin
      errCount++;
      $display("ERR t=%0t %s expected %h got %h", $time, name, expV, actV);
    end
  endtask

  // inputs set here are seen by the DUT on the following edge
  task automatic driveCycle(input logic st, input logic iv, input logic [31:0] word);
    @(posedge clk);
    stall      <= st;
    instrValid <= iv;
    instr      <= word;
  endtask

  ////////////////////
  // monitor
  // runs at the falling edge, inputs and retire record both settled
  always @(negedge clk) begin
    if (rstN && !stall) begin            // coming edge is unstalled
      if (retireValid) begin             // record consumed by that edge
        if (expIdx.size() == 0) begin
          errCount++;
          $display("retirement at %0t with no instruction in flight", $time);
        end else begin
          idx = expIdx.pop_front();
          acc = accEdge.pop_front();
          checkValue("retirePc", corePipePkg::resetPc + 32'd4 * idx, retirePc);
          checkValue("retireRd", vecMem[4*idx+1], {27'b0, retireRd});
          checkValue("retireResult", vecMem[4*idx+2], retireResult);
          checkValue("retireIllegal", vecMem[4*idx+3], {31'b0, retireIllegal});
          checkValue("retire edge", acc + 3, edgeCount - 1); // fixed 3-edge latency
          retiredCount++;
        end
      end
      if (instrValid) begin // accepted on the coming edge
        expIdx.push_back(offerCount);
        accEdge.push_back(edgeCount);
        offerCount++;
      end
      edgeCount++;
    end
  end

  ////////////////////
  // stimulus
  task automatic runVectors();
    int stallLen;
    int gapLen;
    repeat (2) @(posedge clk);
    rstN <= 1'b1;
    repeat (4) driveCycle(1'b0, 1'b0, 32'h0); // quiet, nothing may retire
    for (int k = 0; k < nVec; k++) begin
      stallLen = $unsigned($random(seed)) % (maxStall + 1);
      gapLen   = $unsigned($random(seed)) % (maxGap + 1);
      repeat (stallLen) driveCycle(1'b1, 1'b1, $random(seed)); // junk, strobe ignored
      repeat (gapLen) driveCycle(1'b0, 1'b0, 32'h0);
      driveCycle(1'b0, 1'b1, vecMem[4*k]);
    end
    driveCycle(1'b0, 1'b0, 32'h0);
    while (retiredCount < nVec) @(posedge clk);
    repeat (6) @(posedge clk); // room for stray retirements
  endtask

  initial begin
    seed       = 32'h77dda610;
    rstN       = 1'b0;
    stall      = 1'b0;
    instrValid = 1'b0;
    instr      = '0;
    $readmemh("rv32Pipe_vectors.txt", vecMem);
    if ($isunknown(vecMem[4*nVec-1])) begin
      $display("vector file rv32Pipe_vectors.txt is missing or too short");
      fileBad = 1'b1;
    end else begin
      runVectors();
    end
    $display("summary: %0d of %0d retired, %0d errors", retiredCount, nVec,
             errCount + int'(fileBad));
    if (errCount == 0 && !fileBad)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

  // watchdog
  initial begin
    #(timeoutNs);
    $display("run did not finish within %0d ns, %0d of %0d retired, %0d errors",
             timeoutNs, retiredCount, nVec, errCount);
    $display("Test failures found");
    $finish;
  end

endmodule

// ==== rv32Pipe_vectors.txt ====
// columns: instr  rd  result  illegal (hex), one vector per line in program order
// expected values start from all-zero registers, first pc 0x1000
00500093 01 00000005 0 // addi x1, x0, 5
FFD08113 02 00000002 0 // addi x2, x1, -3
002081B3 03 00000007 0 // add x3, x1, x2
40310233 04 FFFFFFFB 0 // sub x4, x2, x3
002092B3 05 00000014 0 // sll x5, x1, x2
00122333 06 00000001 0 // slt x6, x4, x1
001233B3 07 00000000 0 // sltu x7, x4, x1
00524433 08 FFFFFFEF 0 // xor x8, x4, x5
002254B3 09 3FFFFFFE 0 // srl x9, x4, x2
40225533 0A FFFFFFFE 0 // sra x10, x4, x2
0012E5B3 0B 00000015 0 // or x11, x5, x1
0035F633 0C 00000005 0 // and x12, x11, x3
FFC22693 0D 00000001 0 // slti x13, x4, -4
FFF0B713 0E 00000001 0 // sltiu x14, x1, -1
7FF6C793 0F 000007FE 0 // xori x15, x13, 0x7ff
8017E813 10 FFFFFFFF 0 // ori x16, x15, -2047
0F087893 11 000000F0 0 // andi x17, x16, 0xf0
00489913 12 00000F00 0 // slli x18, x17, 4
01C85993 13 0000000F 0 // srli x19, x16, 28
40125A13 14 FFFFFFFD 0 // srai x20, x4, 1
12345AB7 15 12345000 0 // lui x21, 0x12345
00010B17 16 00011054 0 // auipc x22, 0x10 at pc 0x1054
06308013 00 00000068 0 // addi x0, x1, 99
00100BB3 17 00000005 0 // add x23, x0, x1
FFFFFFFF 00 00000000 1 // unknown opcode
022082B3 00 00000000 1 // mul x5, x1, x2 is not rv32i
40109313 00 00000000 1 // slli with upper bits 0x20
00628C33 18 00000015 0 // add x24, x5, x6
01F06CB3 19 00000000 0 // or x25, x0, x31

// ==== rv32Pipe.f ====
rvIsaPkg.sv
corePipePkg.sv
fetchStage.sv
regFile.sv
decodeStage.sv
executeStage.sv
writebackStage.sv
rv32Pipe.sv
rv32Pipe_sva.sv
rv32PipeTb.sv

// ==== Makefile ====
# Verilator build and run for rv32Pipe

VERILATOR ?= verilator
TOP       ?= rv32PipeTb
FILELIST  ?= rv32Pipe.f
MDIR      ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(MDIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FILELIST)

run: $(SIM) rv32Pipe_vectors.txt
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test failures found" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@grep -q "All tests passed!" $(LOG) || { echo "FAIL: no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(MDIR) $(LOG)
